// File: filelist.f
+incdir+rtl
rtl/mem_bus_pkg.sv
rtl/dma_pkt_pkg.sv
rtl/credit_fifo.sv
rtl/dma_decode.sv
rtl/dma_execute.sv
rtl/dma_result.sv
rtl/dma_bridge_top.sv
verification/tb_dma_bridge.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in sim.log
rm -f sim.log
verilator --binary --timing -f filelist.f --top-module tb_dma_bridge -o tb_dma_bridge \
  && ./obj_dir/tb_dma_bridge > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verification/tb_dma_bridge.sv
// **************************************************
// Memory model returns read data 3 cycles after the
// request and covers the low 1 KB of the address map
// **************************************************
`default_nettype none

`include "dma_config.svh"

module tb_dma_bridge;

  localparam int N_TESTS  = 5;
  localparam int BLEN     = `DMA_BURST_LEN;
  localparam int N_PAIRS  = `DMA_PKT_DEPTH / 2;
  localparam int CDL_LAT  = 40;
  localparam int RD_LAT   = 3;
  localparam int WD_LIMIT = N_TESTS * 2000;

  logic                   core_clk;
  logic                   arst_n;
  logic                   pkt_v;
  logic [`DMA_ADDR_W-1:0] pkt_addr;
  logic                   pkt_write;
  logic                   pkt_credit;
  logic                   wdata_v;
  logic [`DMA_DATA_W-1:0] wdata;
  logic                   wdata_credit;
  logic                   rdata_v;
  logic [`DMA_DATA_W-1:0] rdata;
  logic                   rdata_credit;
  logic                   mem_req;
  logic                   mem_we;
  logic [`DMA_ADDR_W-1:0] mem_addr;
  logic [`DMA_DATA_W-1:0] mem_wdata;
  logic                   mem_ready;
  logic                   mem_rvalid;
  logic [`DMA_DATA_W-1:0] mem_rdata;
  logic                   cdl_en;
  logic [`DMA_LAT_W-1:0]  cdl_lat;
  logic                   cdl_gate;

  // Written by the monitor only
  int          cycle_cnt;
  int          pkt_ret;
  int          wd_ret;
  int          owed;
  logic [31:0] mem_model [256];
  logic [31:0] rdata_q [$];
  int          rdata_cyc_q [$];
  logic [31:0] raddr_q [$];
  int          rreq_cyc_q [$];
  int          gate_cyc_q [$];

  // Written by the test sequence only
  int          errors;
  int          checks;
  int          pkt_sent;
  int          wd_sent;
  logic        credits_on;
  logic [31:0] data_lfsr_q;

  dma_bridge_top u_dut (
    .core_clk_i    (core_clk),
    .arst_n_i      (arst_n),
    .pkt_v_i       (pkt_v),
    .pkt_addr_i    (pkt_addr),
    .pkt_write_i   (pkt_write),
    .pkt_credit_o  (pkt_credit),
    .wdata_v_i     (wdata_v),
    .wdata_i       (wdata),
    .wdata_credit_o(wdata_credit),
    .rdata_v_o     (rdata_v),
    .rdata_o       (rdata),
    .rdata_credit_i(rdata_credit),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_ready_i   (mem_ready),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .cdl_en_i      (cdl_en),
    .cdl_lat_i     (cdl_lat),
    .cdl_gate_o    (cdl_gate)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return {16'hf11d, 6'h00, idx[7:0], 2'b00};
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 32; b++)
    begin
      data_lfsr_q = lfsr_next(data_lfsr_q);
      w = {w[30:0], data_lfsr_q[0]};
    end
    return w;
  endfunction

  initial
  begin
    core_clk = 1'b0;
    forever #5 core_clk = ~core_clk;
  end

  // Memory model, client-side monitor and read credit return
  initial
  begin
    logic [31:0] rdy_lfsr;
    logic        pv [RD_LAT];
    logic [31:0] pd [RD_LAT];
    logic        prev_rreq;
    logic        give;
    logic        rdy_bit;
    rdy_lfsr     = 32'ha1e;
    prev_rreq    = 1'b0;
    mem_ready    = 1'b0;
    mem_rvalid   = 1'b0;
    mem_rdata    = '0;
    rdata_credit = 1'b0;
    cycle_cnt    = 0;
    pkt_ret      = 0;
    wd_ret       = 0;
    owed         = 0;
    for (int i = 0; i < RD_LAT; i++)
    begin
      pv[i] = 1'b0;
      pd[i] = '0;
    end
    for (int i = 0; i < 256; i++)
      mem_model[i] = fill_word(i);
    forever
    begin
      @(posedge core_clk);
      cycle_cnt++;
      for (int i = RD_LAT - 1; i > 0; i--)
      begin
        pv[i] = pv[i - 1];
        pd[i] = pd[i - 1];
      end
      pv[0] = 1'b0;
      if (mem_req && mem_ready)
      begin
        if (mem_we)
          mem_model[mem_addr[9:2]] = mem_wdata;
        else
        begin
          pv[0] = 1'b1;
          pd[0] = mem_model[mem_addr[9:2]];
          raddr_q.push_back(mem_addr);
        end
      end
      // Start of each read burst on the request port
      if (mem_req && !mem_we && !prev_rreq)
        rreq_cyc_q.push_back(cycle_cnt);
      prev_rreq = mem_req && !mem_we;
      if (pkt_credit)
        pkt_ret++;
      if (wdata_credit)
        wd_ret++;
      if (cdl_gate)
        gate_cyc_q.push_back(cycle_cnt);
      if (rdata_v)
      begin
        rdata_q.push_back(rdata);
        rdata_cyc_q.push_back(cycle_cnt);
        owed++;
      end
      give = credits_on && (owed > 0);
      if (give)
        owed--;
      // Ready about three cycles in four
      rdy_lfsr = lfsr_next(rdy_lfsr);
      rdy_bit  = rdy_lfsr[0];
      rdy_lfsr = lfsr_next(rdy_lfsr);
      #1;
      mem_ready    = rdy_bit | rdy_lfsr[0];
      mem_rvalid   = pv[RD_LAT - 1];
      mem_rdata    = pd[RD_LAT - 1];
      rdata_credit = give;
    end
  end

  initial
  begin
    repeat (WD_LIMIT) @(posedge core_clk);
    $display("Timeout: the tests did not finish within %0d cycles", WD_LIMIT);
    $display("Result: FAILED");
    $finish;
  end

  task automatic tick();
    @(posedge core_clk);
    #1;
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic send_packet(input logic [31:0] addr, input logic write);
    while (pkt_sent - pkt_ret >= `DMA_PKT_DEPTH)
      tick();
    pkt_v     = 1'b1;
    pkt_addr  = addr;
    pkt_write = write;
    pkt_sent++;
    tick();
    pkt_v = 1'b0;
  endtask

  task automatic send_word(input logic [31:0] w);
    while (wd_sent - wd_ret >= `DMA_WDATA_DEPTH)
      tick();
    wdata_v = 1'b1;
    wdata   = w;
    wd_sent++;
    tick();
    wdata_v = 1'b0;
  endtask

  task automatic wait_words(input int total);
    while (rdata_q.size() < total)
      tick();
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%s: done, %0d errors", name, errors - err0);
  endtask

  task automatic write_readback();
    logic [31:0] words [BLEN];
    int          err0;
    int          n0;
    err0 = errors;
    for (int k = 0; k < BLEN; k++)
      words[k] = random_word();
    send_packet(32'h40, 1'b1);
    for (int k = 0; k < BLEN; k++)
      send_word(words[k]);
    while (wd_ret < wd_sent)
      tick();
    n0 = rdata_q.size();
    send_packet(32'h40, 1'b0);
    wait_words(n0 + BLEN);
    for (int k = 0; k < BLEN; k++)
      check_eq(rdata_q[n0 + k], words[k], "readback word");
    report_test("write_readback", err0);
  endtask

  task automatic read_alignment();
    int err0;
    int n0;
    int a0;
    err0 = errors;
    n0   = rdata_q.size();
    a0   = raddr_q.size();
    send_packet(32'h8c, 1'b0);
    wait_words(n0 + BLEN);
    for (int k = 0; k < BLEN; k++)
    begin
      check_eq(raddr_q[a0 + k], 32'h80 + 32'(4 * k), "request address");
      check_eq(rdata_q[n0 + k], fill_word(32 + k), "aligned read word");
    end
    report_test("read_alignment", err0);
  endtask

  task automatic read_backpressure();
    int err0;
    int n0;
    int a0;
    err0       = errors;
    n0         = rdata_q.size();
    a0         = raddr_q.size();
    credits_on = 1'b0;
    send_packet(32'h100, 1'b0);
    send_packet(32'h140, 1'b0);
    while (raddr_q.size() < a0 + 2 * BLEN)
      tick();
    // Last words reach the read buffer after the model latency
    repeat (RD_LAT + 2) tick();
    check_eq(32'(rdata_q.size() - n0 <= `DMA_RD_CREDITS), 32'd1, "words sent without credit");
    credits_on = 1'b1;
    wait_words(n0 + 2 * BLEN);
    for (int k = 0; k < 2 * BLEN; k++)
      check_eq(rdata_q[n0 + k], fill_word(64 + (k / BLEN) * 16 + k % BLEN), "held read word");
    report_test("read_backpressure", err0);
  endtask

  task automatic packet_credits();
    logic [31:0] words [N_PAIRS * BLEN];
    int          err0;
    int          n0;
    int          p0;
    int          w0;
    err0 = errors;
    n0   = rdata_q.size();
    p0   = pkt_ret;
    w0   = wd_ret;
    for (int k = 0; k < N_PAIRS * BLEN; k++)
      words[k] = random_word();
    // Write then read back each block with no gap between packets
    for (int p = 0; p < N_PAIRS; p++)
    begin
      send_packet(32'h180 + 32'(p * 16 * 4), 1'b1);
      send_packet(32'h180 + 32'(p * 16 * 4), 1'b0);
    end
    for (int k = 0; k < N_PAIRS * BLEN; k++)
      send_word(words[k]);
    wait_words(n0 + N_PAIRS * BLEN);
    while (pkt_ret < pkt_sent || wd_ret < wd_sent)
      tick();
    check_eq(32'(pkt_ret - p0), 32'(`DMA_PKT_DEPTH), "packet credit pulses");
    check_eq(32'(wd_ret - w0), 32'(N_PAIRS * BLEN), "write-data credit pulses");
    for (int k = 0; k < N_PAIRS * BLEN; k++)
      check_eq(rdata_q[n0 + k], words[k], "burst readback word");
    report_test("packet_credits", err0);
  endtask

  task automatic latency_emulation();
    int err0;
    int n0;
    int r0;
    int g0;
    err0    = errors;
    n0      = rdata_q.size();
    r0      = rreq_cyc_q.size();
    g0      = gate_cyc_q.size();
    cdl_en  = 1'b1;
    cdl_lat = `DMA_LAT_W'(CDL_LAT);
    send_packet(32'h300, 1'b0);
    wait_words(n0 + BLEN);
    check_eq(32'(rdata_cyc_q[n0] - rreq_cyc_q[r0] >= CDL_LAT), 32'd1, "latency below setting");
    check_eq(32'(gate_cyc_q.size() > g0 && gate_cyc_q[g0] < rdata_cyc_q[n0]), 32'd1,
             "cdl_gate_o high before first word");
    for (int k = 0; k < BLEN; k++)
      check_eq(rdata_q[n0 + k], fill_word(192 + k), "delayed read word");
    cdl_en = 1'b0;
    n0     = rdata_q.size();
    g0     = gate_cyc_q.size();
    send_packet(32'h340, 1'b0);
    wait_words(n0 + BLEN);
    check_eq(32'(gate_cyc_q.size() - g0), 32'd0, "cdl_gate_o cycles while disabled");
    for (int k = 0; k < BLEN; k++)
      check_eq(rdata_q[n0 + k], fill_word(208 + k), "undelayed read word");
    report_test("latency_emulation", err0);
  endtask

  initial
  begin
    arst_n      = 1'b0;
    pkt_v       = 1'b0;
    pkt_addr    = '0;
    pkt_write   = 1'b0;
    wdata_v     = 1'b0;
    wdata       = '0;
    cdl_en      = 1'b0;
    cdl_lat     = '0;
    credits_on  = 1'b1;
    errors      = 0;
    checks      = 0;
    pkt_sent    = 0;
    wd_sent     = 0;
    data_lfsr_q = 32'ha1e;
    repeat (8) @(posedge core_clk);
    #1;
    arst_n = 1'b1;
    tick();
    write_readback();
    read_alignment();
    read_backpressure();
    packet_credits();
    latency_emulation();
    $display("Summary: %0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/dma_bridge_top.sv
// **************************************************
// Single clock, single DMA channel
// **************************************************
`default_nettype none

`include "dma_config.svh"

module dma_bridge_top (
  input  logic                    core_clk_i,
  input  logic                    arst_n_i,
  input  logic                    pkt_v_i,
  input  mem_bus_pkg::mem_addr_t  pkt_addr_i,
  input  logic                    pkt_write_i,
  output logic                    pkt_credit_o,
  input  logic                    wdata_v_i,
  input  mem_bus_pkg::mem_word_t  wdata_i,
  output logic                    wdata_credit_o,
  output logic                    rdata_v_o,
  output mem_bus_pkg::mem_word_t  rdata_o,
  input  logic                    rdata_credit_i,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output mem_bus_pkg::mem_addr_t  mem_addr_o,
  output mem_bus_pkg::mem_word_t  mem_wdata_o,
  input  logic                    mem_ready_i,
  input  logic                    mem_rvalid_i,
  input  mem_bus_pkg::mem_word_t  mem_rdata_i,
  input  logic                    cdl_en_i,
  input  mem_bus_pkg::lat_stamp_t cdl_lat_i,
  output logic                    cdl_gate_o
);

  import dma_pkt_pkg::*;
  import mem_bus_pkg::*;

  blk_cmd_t  cmd;
  logic      cmd_v;
  logic      cmd_ready;
  mem_word_t wdata_head;
  logic      wdata_head_v;
  logic      wdata_pop;
  logic      rsv_v;
  logic      rsv_ready;

  dma_decode u_decode (
    .core_clk_i (core_clk_i),
    .arst_n_i   (arst_n_i),
    .pkt_valid_i(pkt_v_i),
    .pkt_i      (dma_pkt_t'{addr: pkt_addr_i, write_not_read: pkt_write_i}),
    .pkt_pop_o  (pkt_credit_o),
    .cmd_v_o    (cmd_v),
    .cmd_o      (cmd),
    .cmd_ready_i(cmd_ready)
  );

  credit_fifo #(
    .payload_t(mem_word_t),
    .DEPTH    (`DMA_WDATA_DEPTH)
  ) u_wdata_fifo (
    .core_clk_i(core_clk_i),
    .arst_n_i  (arst_n_i),
    .push_i    (wdata_v_i),
    .data_i    (wdata_i),
    .pop_i     (wdata_pop),
    .data_o    (wdata_head),
    .valid_o   (wdata_head_v),
    .credit_o  (wdata_credit_o)
  );

  dma_execute u_execute (
    .core_clk_i   (core_clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_v_i      (cmd_v),
    .cmd_i        (cmd),
    .cmd_ready_o  (cmd_ready),
    .wdata_valid_i(wdata_head_v),
    .wdata_i      (wdata_head),
    .wdata_pop_o  (wdata_pop),
    .rsv_v_o      (rsv_v),
    .rsv_ready_i  (rsv_ready),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_ready_i  (mem_ready_i)
  );

  dma_result u_result (
    .core_clk_i    (core_clk_i),
    .arst_n_i      (arst_n_i),
    .rsv_v_i       (rsv_v),
    .rsv_ready_o   (rsv_ready),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .cdl_en_i      (cdl_en_i),
    .cdl_lat_i     (cdl_lat_i),
    .cdl_gate_o    (cdl_gate_o),
    .rdata_v_o     (rdata_v_o),
    .rdata_o       (rdata_o),
    .rdata_credit_i(rdata_credit_i)
  );

endmodule

`default_nettype wire

// File: rtl/dma_result.sv
// **************************************************
// Emulated latency is measured with wrapping stamps,
// so a word must not wait 2**DMA_LAT_W cycles
// **************************************************
`default_nettype none

`include "dma_config.svh"

module dma_result (
  input  logic                    core_clk_i,
  input  logic                    arst_n_i,
  input  logic                    rsv_v_i,
  output logic                    rsv_ready_o,
  input  logic                    mem_rvalid_i,
  input  mem_bus_pkg::mem_word_t  mem_rdata_i,
  input  logic                    cdl_en_i,
  input  mem_bus_pkg::lat_stamp_t cdl_lat_i,
  output logic                    cdl_gate_o,
  output logic                    rdata_v_o,
  output mem_bus_pkg::mem_word_t  rdata_o,
  input  logic                    rdata_credit_i
);

  import mem_bus_pkg::*;

  localparam int RSV_W = $clog2(`DMA_RBUF_DEPTH + 1);
  localparam int CRD_W = $clog2(`DMA_RD_CREDITS + 1);
  localparam int BEAT_W = (`DMA_BURST_LEN > 1) ? $clog2(`DMA_BURST_LEN) : 1;
  localparam logic [RSV_W-1:0] RSV_LIMIT = RSV_W'(`DMA_RBUF_DEPTH - `DMA_BURST_LEN);
  localparam logic [RSV_W-1:0] RSV_BURST = RSV_W'(`DMA_BURST_LEN);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DMA_BURST_LEN - 1);

  logic [RSV_W-1:0]  rsv_cnt_q;
  logic [CRD_W-1:0]  rd_crd_q;
  logic [BEAT_W-1:0] beat_q;
  lat_stamp_t        cycle_q;
  lat_stamp_t        stamp_head;
  lat_stamp_t        elapsed;
  logic              stamp_v;
  logic              rbuf_v;
  logic              slot_free;
  logic              burst_done;
  logic              grant;
  logic              lat_ok;
  logic              credited;
  logic              send;

  credit_fifo #(
    .payload_t(mem_word_t),
    .DEPTH    (`DMA_RBUF_DEPTH)
  ) u_rbuf (
    .core_clk_i(core_clk_i),
    .arst_n_i  (arst_n_i),
    .push_i    (mem_rvalid_i),
    .data_i    (mem_rdata_i),
    .pop_i     (send),
    .data_o    (rdata_o),
    .valid_o   (rbuf_v),
    .credit_o  (slot_free)
  );

  // Holds one stamp per reserved burst until its last word leaves
  credit_fifo #(
    .payload_t(lat_stamp_t),
    .DEPTH    (`DMA_RBUF_DEPTH / `DMA_BURST_LEN)
  ) u_stamp_q (
    .core_clk_i(core_clk_i),
    .arst_n_i  (arst_n_i),
    .push_i    (grant),
    .data_i    (cycle_q),
    .pop_i     (send & (beat_q == LAST_BEAT)),
    .data_o    (stamp_head),
    .valid_o   (stamp_v),
    .credit_o  (burst_done)
  );

  assign rsv_ready_o = (rsv_cnt_q <= RSV_LIMIT);
  assign grant       = rsv_v_i & rsv_ready_o;

  assign elapsed  = cycle_q - stamp_head;
  assign lat_ok   = ~cdl_en_i | (stamp_v & (elapsed >= cdl_lat_i));
  assign credited = rbuf_v & (rd_crd_q != '0);

  assign send       = credited & lat_ok;
  assign rdata_v_o  = send;
  assign cdl_gate_o = credited & ~lat_ok;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rsv_cnt_q <= '0;
      rd_crd_q  <= CRD_W'(`DMA_RD_CREDITS);
      beat_q    <= '0;
      cycle_q   <= '0;
    end
    else
    begin
      cycle_q   <= cycle_q + 1'b1;
      rsv_cnt_q <= rsv_cnt_q + (grant ? RSV_BURST : '0) - RSV_W'(slot_free);
      rd_crd_q  <= rd_crd_q + CRD_W'(rdata_credit_i) - CRD_W'(send);
      if (burst_done)
        beat_q <= '0;
      else if (send)
        beat_q <= beat_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/dma_execute.sv
// **************************************************
// One block at a time. Reads wait for a reservation
// in the result buffer before the first request
// **************************************************
`default_nettype none

`include "dma_config.svh"

module dma_execute (
  input  logic                   core_clk_i,
  input  logic                   arst_n_i,
  input  logic                   cmd_v_i,
  input  dma_pkt_pkg::blk_cmd_t  cmd_i,
  output logic                   cmd_ready_o,
  input  logic                   wdata_valid_i,
  input  mem_bus_pkg::mem_word_t wdata_i,
  output logic                   wdata_pop_o,
  output logic                   rsv_v_o,
  input  logic                   rsv_ready_i,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output mem_bus_pkg::mem_addr_t mem_addr_o,
  output mem_bus_pkg::mem_word_t mem_wdata_o,
  input  logic                   mem_ready_i
);

  import dma_pkt_pkg::*;
  import mem_bus_pkg::*;

  localparam int BEAT_W = (`DMA_BURST_LEN > 1) ? $clog2(`DMA_BURST_LEN) : 1;
  localparam int WORD_OFF_W = $clog2(`DMA_DATA_W / 8);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DMA_BURST_LEN - 1);

  typedef enum logic [1:0]
  {
    e_idle,
    e_wr_burst,
    e_rd_burst
  } exe_state_e;

  exe_state_e        state_q;
  mem_addr_t         base_q;
  logic [BEAT_W-1:0] beat_q;
  logic              rsv_done_q;
  logic              rd_go;
  logic              xfer;

  assign cmd_ready_o = (state_q == e_idle);
  assign rsv_v_o     = (state_q == e_rd_burst) & ~rsv_done_q;

  // First read request goes out in the grant cycle
  assign rd_go = rsv_done_q | (rsv_v_o & rsv_ready_i);

  assign mem_we_o    = (state_q == e_wr_burst);
  assign mem_req_o   = mem_we_o ? wdata_valid_i : ((state_q == e_rd_burst) & rd_go);
  assign mem_addr_o  = base_q + (mem_addr_t'(beat_q) << WORD_OFF_W);
  assign mem_wdata_o = wdata_i;
  assign xfer        = mem_req_o & mem_ready_i;
  assign wdata_pop_o = mem_we_o & xfer;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q    <= e_idle;
      beat_q     <= '0;
      rsv_done_q <= 1'b0;
    end
    else if (state_q == e_idle)
    begin
      if (cmd_v_i)
        state_q <= (cmd_i.op == e_dma_write) ? e_wr_burst : e_rd_burst;
      beat_q     <= '0;
      rsv_done_q <= 1'b0;
    end
    else
    begin
      if (rsv_v_o & rsv_ready_i)
        rsv_done_q <= 1'b1;
      if (xfer)
      begin
        beat_q <= beat_q + 1'b1;
        if (beat_q == LAST_BEAT)
        begin
          state_q    <= e_idle;
          rsv_done_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (cmd_v_i & cmd_ready_o)
      base_q <= cmd_i.addr;
  end

endmodule

`default_nettype wire

// File: rtl/dma_decode.sv
// **************************************************
// Packet FIFO plus a one-entry command register
// **************************************************
`default_nettype none

`include "dma_config.svh"

module dma_decode (
  input  logic                  core_clk_i,
  input  logic                  arst_n_i,
  input  logic                  pkt_valid_i,
  input  dma_pkt_pkg::dma_pkt_t pkt_i,
  output logic                  pkt_pop_o,
  output logic                  cmd_v_o,
  output dma_pkt_pkg::blk_cmd_t cmd_o,
  input  logic                  cmd_ready_i
);

  import dma_pkt_pkg::*;
  import mem_bus_pkg::*;

  // Byte offset bits inside one block
  localparam int OFF_W = $clog2(`DMA_BURST_LEN * `DMA_DATA_W / 8);
  localparam mem_addr_t BLK_MASK = ~mem_addr_t'((1 << OFF_W) - 1);

  dma_pkt_t pkt_head;
  logic     pkt_head_v;
  logic     pkt_pop;
  blk_cmd_t cmd_next;
  blk_cmd_t cmd_q;
  logic     cmd_v_q;

  credit_fifo #(
    .payload_t(dma_pkt_t),
    .DEPTH    (`DMA_PKT_DEPTH)
  ) u_pkt_fifo (
    .core_clk_i(core_clk_i),
    .arst_n_i  (arst_n_i),
    .push_i    (pkt_valid_i),
    .data_i    (pkt_i),
    .pop_i     (pkt_pop),
    .data_o    (pkt_head),
    .valid_o   (pkt_head_v),
    .credit_o  (pkt_pop_o)
  );

  // Load when the stage is empty or being drained
  assign pkt_pop = pkt_head_v & (~cmd_v_q | cmd_ready_i);

  assign cmd_next.addr = pkt_head.addr & BLK_MASK;
  assign cmd_next.op   = pkt_head.write_not_read ? e_dma_write : e_dma_read;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      cmd_v_q <= 1'b0;
    else if (pkt_pop)
      cmd_v_q <= 1'b1;
    else if (cmd_ready_i)
      cmd_v_q <= 1'b0;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (pkt_pop)
      cmd_q <= cmd_next;
  end

  assign cmd_v_o = cmd_v_q;
  assign cmd_o   = cmd_q;

endmodule

`default_nettype wire

// File: rtl/credit_fifo.sv
// **************************************************
// No full flag. The writer must hold a credit, so a
// push into a full FIFO is a protocol error
// **************************************************
`default_nettype none

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     core_clk_i,
  input  logic     arst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     valid_o,
  output logic     credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_pop;

  assign valid_o  = (count_q != '0);
  assign do_pop   = pop_i & valid_o;
  assign data_o   = mem_q[rd_ptr_q];
  assign credit_o = do_pop;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (push_i)
      mem_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

// File: rtl/dma_pkt_pkg.sv
// **************************************************
// Core-side packet and command types
// **************************************************
`default_nettype none

package dma_pkt_pkg;

  typedef enum logic
  {
    e_dma_read  = 1'b0,
    e_dma_write = 1'b1
  } dma_op_e;

  // As sent by the client
  typedef struct packed
  {
    mem_bus_pkg::mem_addr_t addr;
    logic                   write_not_read;
  } dma_pkt_t;

  // Address already aligned to the block
  typedef struct packed
  {
    mem_bus_pkg::mem_addr_t addr;
    dma_op_e                op;
  } blk_cmd_t;

endpackage

`default_nettype wire

// File: rtl/mem_bus_pkg.sv
// **************************************************
// Memory bus types. Stamps wrap at 2**DMA_LAT_W
// **************************************************
`default_nettype none

`include "dma_config.svh"

package mem_bus_pkg;

  typedef logic [`DMA_DATA_W-1:0] mem_word_t;

  // Byte address
  typedef logic [`DMA_ADDR_W-1:0] mem_addr_t;

  // Free-running cycle stamp for latency emulation
  typedef logic [`DMA_LAT_W-1:0] lat_stamp_t;

endpackage

`default_nettype wire

// File: rtl/dma_config.svh
// **************************************************
// Widths and depths of the bridge. BURST_LEN, the
// FIFO depths and DATA_W/8 must be powers of two
// **************************************************
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

`define DMA_ADDR_W 32
`define DMA_DATA_W 32
`define DMA_BURST_LEN 4

// Depths double as the client's initial credits
`define DMA_PKT_DEPTH 4
`define DMA_WDATA_DEPTH 8

`define DMA_RBUF_DEPTH 8
`define DMA_RD_CREDITS 4
`define DMA_LAT_W 16

`endif
